// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = audio_mixer_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result line"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtl/audio_fmt_pkg.sv
`default_nettype none

package audio_fmt_pkg;

	// raw FM word as delivered by the synthesizer
	localparam int FM_WORD_W = 10;

	// decoded signed FM value
	localparam int FM_VAL_W = 10;

	// offset-binary code of the ladder DAC form
	localparam int LADDER_CODE_W = 9;
	localparam int LADDER_BIAS = 256;

	localparam logic FM_MODE_LADDER = 1'b0;
	localparam logic FM_MODE_TWOS = 1'b1;

	// one input word, read either as ladder code or as two's complement
	typedef union packed {
		struct packed {
			logic spare;
			logic [LADDER_CODE_W-1:0] code;
		} ladder;
		logic signed [FM_WORD_W-1:0] twos;
	} fm_word_u;

endpackage

`default_nettype wire

// File: rtl/audio_mix_pkg.sv
`default_nettype none

package audio_mix_pkg;

	// PSG level, read as unsigned
	localparam int PSG_W = 16;

	// FM scale factors per format
	localparam int unsigned GAIN_LADDER = 64;
	localparam int unsigned GAIN_TWOS = 192;

	// unclipped sum, signed
	localparam int MIX_W = 19;

	// board output, signed
	localparam int OUT_W = 18;
	localparam int OUT_MAX = 131071;
	localparam int OUT_MIN = -131072;

	// edges from the sampling edge to the output edge
	localparam int PIPE_LAT = 2;

endpackage

`default_nettype wire

// File: rtl/audio_mixer_top.sv
`timescale 1ns/1ns
`default_nettype none

module audio_mixer_top
	import audio_fmt_pkg::*, audio_mix_pkg::*;
	(
	input wire logic MCLK,
	input wire logic reset_i,

	// FM and PSG sample in
	input wire logic sample_strobe_i,
	input wire logic fm_mode_i,
	input wire logic [FM_WORD_W-1:0] fm_left_i,
	input wire logic [FM_WORD_W-1:0] fm_right_i,
	input wire logic [PSG_W-1:0] psg_i,

	// board audio out
	output logic out_valid_o,
	output logic [OUT_W-1:0] audio_left_o,
	output logic [OUT_W-1:0] audio_right_o,
	output logic clip_o
	);

	logic mix_valid;
	logic signed [MIX_W-1:0] mix_left;
	logic signed [MIX_W-1:0] mix_right;

	fm_pcm_if pcm ();

	fm_decode decode
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.sample_strobe_i(sample_strobe_i),
		.fm_mode_i(fm_mode_i),
		.fm_left_i(fm_word_u'(fm_left_i)),
		.fm_right_i(fm_word_u'(fm_right_i)),
		.psg_i(psg_i),
		.pcm(pcm.source)
		);

	fm_psg_mix mix
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.pcm(pcm.sink),
		.mix_valid_o(mix_valid),
		.mix_left_o(mix_left),
		.mix_right_o(mix_right)
		);

	mix_clip clip
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.mix_valid_i(mix_valid),
		.mix_left_i(mix_left),
		.mix_right_i(mix_right),
		.out_valid_o(out_valid_o),
		.audio_left_o(audio_left_o),
		.audio_right_o(audio_right_o),
		.clip_o(clip_o)
		);

endmodule

`default_nettype wire

// File: rtl/fm_decode.sv
`timescale 1ns/1ns
`default_nettype none

module fm_decode
	import audio_fmt_pkg::*, audio_mix_pkg::*;
	(
	input wire logic MCLK,
	input wire logic reset_i,

	input wire logic sample_strobe_i,
	input wire logic fm_mode_i,
	input wire fm_word_u fm_left_i,
	input wire fm_word_u fm_right_i,
	input wire logic [PSG_W-1:0] psg_i,

	fm_pcm_if.source pcm
	);

	logic signed [FM_VAL_W-1:0] left_dec;
	logic signed [FM_VAL_W-1:0] right_dec;

	// ladder code is offset binary around the midpoint
	function automatic logic signed [FM_VAL_W-1:0] decode_fm
		(
		input fm_word_u word,
		input logic mode
		);
		logic signed [FM_VAL_W-1:0] val;
		if (mode == FM_MODE_LADDER)
		begin
			val = $signed({1'b0, word.ladder.code}) - $signed(FM_VAL_W'(LADDER_BIAS));
		end
		else
		begin
			val = word.twos;
		end
		return val;
	endfunction

	always_comb
	begin
		left_dec = decode_fm(fm_left_i, fm_mode_i);
		right_dec = decode_fm(fm_right_i, fm_mode_i);
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pcm.valid <= 1'b0;
		end
		else
		begin
			pcm.valid <= sample_strobe_i;
		end
	end

	// sample held until the next strobe
	always_ff @(posedge MCLK)
	begin
		if (sample_strobe_i)
		begin
			pcm.mode <= fm_mode_i;
			pcm.left <= left_dec;
			pcm.right <= right_dec;
			pcm.psg <= psg_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fm_pcm_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fm_pcm_if
	import audio_fmt_pkg::*, audio_mix_pkg::*;
	();

	logic valid;
	logic mode;
	logic signed [FM_VAL_W-1:0] left;
	logic signed [FM_VAL_W-1:0] right;
	logic [PSG_W-1:0] psg;

	modport source
		(
		output valid,
		output mode,
		output left,
		output right,
		output psg
		);

	modport sink
		(
		input valid,
		input mode,
		input left,
		input right,
		input psg
		);

endinterface

`default_nettype wire

// File: rtl/fm_psg_mix.sv
`timescale 1ns/1ns
`default_nettype none

module fm_psg_mix
	import audio_fmt_pkg::*, audio_mix_pkg::*;
	(
	input wire logic MCLK,
	input wire logic reset_i,

	fm_pcm_if.sink pcm,

	output logic mix_valid_o,
	output logic signed [MIX_W-1:0] mix_left_o,
	output logic signed [MIX_W-1:0] mix_right_o
	);

	logic signed [MIX_W-1:0] psg_ext;
	logic signed [MIX_W-1:0] left_scaled;
	logic signed [MIX_W-1:0] right_scaled;

	// shift-and-add by a constant gain, 192 becomes <<7 plus <<6
	function automatic logic signed [MIX_W-1:0] scale_fm
		(
		input logic signed [FM_VAL_W-1:0] val,
		input int unsigned gain
		);
		logic signed [MIX_W-1:0] ext;
		logic signed [MIX_W-1:0] acc;
		ext = val;
		acc = '0;
		for (int i = 0; i < MIX_W; i++)
		begin
			if (gain[i])
			begin
				acc = acc + (ext <<< i);
			end
		end
		return acc;
	endfunction

	// PSG level is never negative
	assign psg_ext = $signed({{(MIX_W-PSG_W){1'b0}}, pcm.psg});

	always_comb
	begin
		if (pcm.mode == FM_MODE_TWOS)
		begin
			left_scaled = scale_fm(pcm.left, GAIN_TWOS);
			right_scaled = scale_fm(pcm.right, GAIN_TWOS);
		end
		else
		begin
			left_scaled = scale_fm(pcm.left, GAIN_LADDER);
			right_scaled = scale_fm(pcm.right, GAIN_LADDER);
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			mix_valid_o <= 1'b0;
		end
		else
		begin
			mix_valid_o <= pcm.valid;
		end
	end

	// full precision, clipping happens downstream
	always_ff @(posedge MCLK)
	begin
		if (pcm.valid)
		begin
			mix_left_o <= left_scaled + psg_ext;
			mix_right_o <= right_scaled + psg_ext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mix_clip.sv
`timescale 1ns/1ns
`default_nettype none

module mix_clip
	import audio_mix_pkg::*;
	(
	input wire logic MCLK,
	input wire logic reset_i,

	input wire logic mix_valid_i,
	input wire logic signed [MIX_W-1:0] mix_left_i,
	input wire logic signed [MIX_W-1:0] mix_right_i,

	output logic out_valid_o,
	output logic signed [OUT_W-1:0] audio_left_o,
	output logic signed [OUT_W-1:0] audio_right_o,
	output logic clip_o
	);

	logic signed [OUT_W-1:0] left_sat;
	logic signed [OUT_W-1:0] right_sat;
	logic left_hit;
	logic right_hit;

	function automatic void saturate
		(
		input logic signed [MIX_W-1:0] val,
		output logic signed [OUT_W-1:0] sat,
		output logic hit
		);
		if (val > OUT_MAX)
		begin
			sat = OUT_W'(OUT_MAX);
			hit = 1'b1;
		end
		else if (val < OUT_MIN)
		begin
			sat = OUT_W'(OUT_MIN);
			hit = 1'b1;
		end
		else
		begin
			sat = val[OUT_W-1:0];
			hit = 1'b0;
		end
	endfunction

	always_comb
	begin
		saturate(mix_left_i, left_sat, left_hit);
		saturate(mix_right_i, right_sat, right_hit);
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			out_valid_o <= 1'b0;
			clip_o <= 1'b0;
		end
		else
		begin
			out_valid_o <= mix_valid_i;
			if (mix_valid_i)
			begin
				clip_o <= left_hit | right_hit;
			end
		end
	end

	// outputs hold the last result between samples
	always_ff @(posedge MCLK)
	begin
		if (mix_valid_i)
		begin
			audio_left_o <= left_sat;
			audio_right_o <= right_sat;
		end
	end

endmodule

`default_nettype wire

// File: verification/audio_mixer_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module audio_mixer_assertions
	import audio_mix_pkg::*;
	(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire logic sample_strobe_i,
	input wire logic out_valid_i,
	input wire logic [OUT_W-1:0] audio_left_i,
	input wire logic [OUT_W-1:0] audio_right_i,
	input wire logic clip_i
	);

	// strobe edge to the edge that sees out_valid high
	latency_fwd: assert property (@(posedge MCLK) disable iff (reset_i)
		sample_strobe_i |-> ##(PIPE_LAT+1) out_valid_i)
		else $error("out_valid_o missing after a sample strobe");

	latency_back: assert property (@(posedge MCLK) disable iff (reset_i)
		out_valid_i |-> $past(sample_strobe_i, PIPE_LAT+1))
		else $error("out_valid_o without a matching sample strobe");

	// clip only with a channel pinned at a limit
	clip_at_limit: assert property (@(posedge MCLK) disable iff (reset_i)
		clip_i |-> ($signed(audio_left_i) == OUT_MAX) || ($signed(audio_left_i) == OUT_MIN)
			|| ($signed(audio_right_i) == OUT_MAX) || ($signed(audio_right_i) == OUT_MIN))
		else $error("clip_o high with both channels inside the limits");

	no_valid_in_reset: assert property (@(posedge MCLK)
		reset_i |=> !out_valid_i)
		else $error("out_valid_o high during reset");

endmodule

bind audio_mixer_top audio_mixer_assertions asrt0
	(
	.MCLK(MCLK),
	.reset_i(reset_i),
	.sample_strobe_i(sample_strobe_i),
	.out_valid_i(out_valid_o),
	.audio_left_i(audio_left_o),
	.audio_right_i(audio_right_o),
	.clip_i(clip_o)
	);

`default_nettype wire

// File: verification/audio_mixer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module audio_mixer_tb
	import audio_fmt_pkg::*, audio_mix_pkg::*;
	();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 2;
	localparam int N_HAND = 13;
	localparam int N_RAND = 32;
	// hand entries run alone and back to back, plus the reset check
	localparam int N_RUNS = 2 * N_HAND + N_RAND + 1;
	localparam int WATCHDOG_CYCLES = N_RUNS * 8 + RESET_CYCLES;
	localparam int WAIT_LIMIT = PIPE_LAT + 4;
	localparam logic [31:0] SEED = 32'h91300f36;

	typedef struct {
		string name;
		logic mode;
		logic [FM_WORD_W-1:0] left;
		logic [FM_WORD_W-1:0] right;
		logic [PSG_W-1:0] psg;
		int exp_left;
		int exp_right;
		logic exp_clip;
	} vec_t;

	logic MCLK;
	logic reset_i;
	logic sample_strobe_i;
	logic fm_mode_i;
	logic [FM_WORD_W-1:0] fm_left_i;
	logic [FM_WORD_W-1:0] fm_right_i;
	logic [PSG_W-1:0] psg_i;
	logic out_valid_o;
	logic [OUT_W-1:0] audio_left_o;
	logic [OUT_W-1:0] audio_right_o;
	logic clip_o;

	vec_t vecs[$];
	int pass_count;
	int fail_count;
	logic [31:0] rng_state;

	audio_mixer_top dut0
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.sample_strobe_i(sample_strobe_i),
		.fm_mode_i(fm_mode_i),
		.fm_left_i(fm_left_i),
		.fm_right_i(fm_right_i),
		.psg_i(psg_i),
		.out_valid_o(out_valid_o),
		.audio_left_o(audio_left_o),
		.audio_right_o(audio_right_o),
		.clip_o(clip_o)
		);

	initial
	begin
		MCLK = 1'b0;
		forever #(CLK_PERIOD/2) MCLK = ~MCLK;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// decode, gain, PSG add and clamp for one channel
	function automatic int expected_channel
		(
		input logic mode,
		input logic [FM_WORD_W-1:0] word,
		input logic [PSG_W-1:0] psg,
		output logic clipped
		);
		fm_word_u w;
		int val;
		int gain;
		int sum;
		w = word;
		if (mode == FM_MODE_LADDER)
		begin
			val = int'(w.ladder.code) - LADDER_BIAS;
			gain = GAIN_LADDER;
		end
		else
		begin
			val = int'($signed(w.twos));
			gain = GAIN_TWOS;
		end
		sum = val * gain + int'(psg);
		clipped = (sum > OUT_MAX) || (sum < OUT_MIN);
		if (sum > OUT_MAX)
		begin
			sum = OUT_MAX;
		end
		else if (sum < OUT_MIN)
		begin
			sum = OUT_MIN;
		end
		return sum;
	endfunction

	task automatic add_vec(input string name, input logic mode, input logic [FM_WORD_W-1:0] l,
		input logic [FM_WORD_W-1:0] r, input logic [PSG_W-1:0] psg, input int el, input int er,
		input logic ec);
		vec_t v;
		v.name = name;
		v.mode = mode;
		v.left = l;
		v.right = r;
		v.psg = psg;
		v.exp_left = el;
		v.exp_right = er;
		v.exp_clip = ec;
		vecs.push_back(v);
	endtask

	task automatic build_table;
		add_vec("lad_min_max", FM_MODE_LADDER, 10'h000, 10'h1ff, 0, -16384, 16320, 0);
		add_vec("lad_mid", FM_MODE_LADDER, 10'h100, 10'h100, 0, 0, 0, 0);
		add_vec("lad_psg_a", FM_MODE_LADDER, 10'h000, 10'h100, 1000, -15384, 1000, 0);
		add_vec("lad_psg_b", FM_MODE_LADDER, 10'h1ff, 10'h000, 1000, 17320, -15384, 0);
		// top bit is ignored in the ladder form
		add_vec("lad_spare", FM_MODE_LADDER, 10'h3ff, 10'h200, 0, 16320, -16384, 0);
		add_vec("twos_min_max", FM_MODE_TWOS, 10'h200, 10'h1ff, 0, -98304, 98112, 0);
		add_vec("twos_m1_zero", FM_MODE_TWOS, 10'h3ff, 10'h000, 0, -192, 0, 0);
		add_vec("twos_zero_m1", FM_MODE_TWOS, 10'h000, 10'h3ff, 0, 0, -192, 0);
		add_vec("sat_left", FM_MODE_TWOS, 10'h1ff, 10'h12c, 16'hffff, 131071, 123135, 1);
		add_vec("sat_right", FM_MODE_TWOS, 10'h12c, 10'h1ff, 16'hffff, 123135, 131071, 1);
		add_vec("sat_edge", FM_MODE_TWOS, 10'h12c, 10'h12c, 16'hffff, 123135, 123135, 0);
		add_vec("sat_neg", FM_MODE_TWOS, 10'h200, 10'h200, 16'hffff, -32769, -32769, 0);
		add_vec("lad_loud", FM_MODE_LADDER, 10'h1ff, 10'h1ff, 16'hffff, 81855, 81855, 0);
	endtask

	task automatic add_random;
		logic [31:0] r1;
		logic [31:0] r2;
		logic cl;
		logic cr;
		int el;
		int er;
		for (int i = 0; i < N_RAND; i++)
		begin
			rng_state = xorshift32(rng_state);
			r1 = rng_state;
			rng_state = xorshift32(rng_state);
			r2 = rng_state;
			el = expected_channel(r1[0], r1[10:1], r2[15:0], cl);
			er = expected_channel(r1[0], r1[20:11], r2[15:0], cr);
			add_vec($sformatf("random_%0d", i), r1[0], r1[10:1], r1[20:11], r2[15:0],
				el, er, cl | cr);
		end
	endtask

	task automatic end_test(input string name, input bit bad);
		if (bad)
		begin
			fail_count++;
			$display("test %s failed", name);
		end
		else
		begin
			pass_count++;
			$display("test %s passed", name);
		end
	endtask

	task automatic check_result(input int idx, input string phase);
		vec_t v;
		bit bad;
		v = vecs[idx];
		bad = 1'b0;
		if (audio_left_o !== OUT_W'(v.exp_left))
		begin
			$display("CHECK FAILED %s %s left expected %0d actual %0d",
				phase, v.name, v.exp_left, $signed(audio_left_o));
			bad = 1'b1;
		end
		if (audio_right_o !== OUT_W'(v.exp_right))
		begin
			$display("CHECK FAILED %s %s right expected %0d actual %0d",
				phase, v.name, v.exp_right, $signed(audio_right_o));
			bad = 1'b1;
		end
		if (clip_o !== v.exp_clip)
		begin
			$display("CHECK FAILED %s %s clip expected %0b actual %0b",
				phase, v.name, v.exp_clip, clip_o);
			bad = 1'b1;
		end
		end_test({phase, " ", v.name}, bad);
	endtask

	// one strobe per falling edge, back to back
	task automatic drive_samples(input int first, input int count);
		for (int i = first; i < first + count; i++)
		begin
			@(negedge MCLK);
			sample_strobe_i = 1'b1;
			fm_mode_i = vecs[i].mode;
			fm_left_i = vecs[i].left;
			fm_right_i = vecs[i].right;
			psg_i = vecs[i].psg;
		end
		@(negedge MCLK);
		sample_strobe_i = 1'b0;
	endtask

	task automatic collect_results(input int first, input int count, input string phase);
		int waited;
		bit found;
		for (int i = first; i < first + count; i++)
		begin
			waited = 0;
			found = 1'b0;
			while (!found && waited < WAIT_LIMIT)
			begin
				@(negedge MCLK);
				if (out_valid_o === 1'b1)
				begin
					found = 1'b1;
				end
				else
				begin
					waited++;
				end
			end
			if (found)
			begin
				check_result(i, phase);
			end
			else
			begin
				$display("no output appeared for %s %s", phase, vecs[i].name);
				end_test({phase, " ", vecs[i].name}, 1'b1);
			end
		end
	endtask

	task automatic run_samples(input int first, input int count, input string phase);
		fork
			drive_samples(first, count);
			collect_results(first, count, phase);
		join
	endtask

	initial
	begin
		bit bad;
		reset_i = 1'b1;
		sample_strobe_i = 1'b0;
		fm_mode_i = FM_MODE_LADDER;
		fm_left_i = '0;
		fm_right_i = '0;
		psg_i = '0;
		pass_count = 0;
		fail_count = 0;
		rng_state = SEED;
		bad = 1'b0;
		build_table();

		// no valid in reset nor while idle afterwards
		for (int i = 0; i < RESET_CYCLES + 4; i++)
		begin
			@(negedge MCLK);
			// nothing is registered before the first rising edge
			if (i > 0 && out_valid_o !== 1'b0)
			begin
				$display("out_valid_o was high with no sample strobed");
				bad = 1'b1;
			end
			if (i == RESET_CYCLES)
			begin
				reset_i = 1'b0;
			end
		end
		end_test("reset_idle", bad);

		for (int i = 0; i < N_HAND; i++)
		begin
			run_samples(i, 1, "single");
		end
		run_samples(0, N_HAND, "burst");
		add_random();
		for (int i = N_HAND; i < N_HAND + N_RAND; i++)
		begin
			run_samples(i, 1, "single");
		end

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rtl/audio_fmt_pkg.sv
rtl/audio_mix_pkg.sv
rtl/fm_pcm_if.sv
rtl/fm_decode.sv
rtl/fm_psg_mix.sv
rtl/mix_clip.sv
rtl/audio_mixer_top.sv
verification/audio_mixer_assertions.sv
verification/audio_mixer_tb.sv
